//--- lsu_bus_pkg.sv
// single-beat 32-bit AXI bus only; a word is four byte lanes, little endian
package lsu_bus_pkg;

    // byte address of a transfer
    localparam int ADDR_W = 32;

    // one data beat
    localparam int DATA_W = 32;

    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    // one bus word, seen whole, as byte lanes or as half-word lanes
    typedef union packed {
        logic [DATA_W-1:0]            word;
        logic [STRB_W-1:0][7:0]       bytes;
        logic [STRB_W/2-1:0][15:0]    halves;
    } lsu_word_u;

endpackage

//--- lsu_op_pkg.sv
// RV32 register file of 32 entries; commit ids wrap at 16 and are only passed through
package lsu_op_pkg;

    // destination register index
    localparam int REG_ADDR_W = 5;

    // tag the core uses to retire loads
    localparam int COMMIT_ID_W = 4;

    // load kinds, coded as the RV32 funct3
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_kind_e;

    // store sizes, coded as the low funct3 bits
    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } store_size_e;

endpackage

//--- lsu_issue.sv
// core must hold its request while mem_stall_o is high; an interrupt drops it at once
module lsu_issue (
    input  logic                           req_mem_i,
    input  logic                           mem_load_i,
    input  logic                           mem_store_i,
    input  logic                           int_assert_i,
    input  logic [lsu_bus_pkg::ADDR_W-1:0] op1_i,
    input  logic [lsu_bus_pkg::ADDR_W-1:0] op2_i,
    input  logic                           m_axi_arready_i,
    input  logic                           m_axi_awready_i,
    input  logic                           load_queue_full_i,
    input  logic                           wdata_queue_full_i,
    output logic [lsu_bus_pkg::ADDR_W-1:0] addr_o,
    output logic [1:0]                     byte_off_o,
    output logic                           load_fire_o,
    output logic                           store_fire_o,
    output logic                           m_axi_arvalid_o,
    output logic                           m_axi_awvalid_o,
    output logic                           mem_stall_o
);

    logic req_valid;
    logic load_req;
    logic store_req;

    assign addr_o     = op1_i + op2_i;
    assign byte_off_o = addr_o[1:0];

    // interrupt masks the request
    assign req_valid = req_mem_i & ~int_assert_i;
    assign load_req  = req_valid & mem_load_i;
    assign store_req = req_valid & mem_store_i;

    // a full queue holds the address back, so no beat is lost
    assign m_axi_arvalid_o = load_req & ~load_queue_full_i;
    assign m_axi_awvalid_o = store_req & ~wdata_queue_full_i;

    assign load_fire_o  = m_axi_arvalid_o & m_axi_arready_i;
    assign store_fire_o = m_axi_awvalid_o & m_axi_awready_i;

    assign mem_stall_o = (load_req & (~m_axi_arready_i | load_queue_full_i))
                       | (store_req & (~m_axi_awready_i | wdata_queue_full_i));

endmodule

//--- lsu_store_align.sv
// misaligned stores are not split: SH uses offset bit 1 only, SW ignores the offset
module lsu_store_align (
    input  logic [lsu_bus_pkg::DATA_W-1:0] rs2_data_i,
    input  lsu_op_pkg::store_size_e        store_size_i,
    input  logic [1:0]                     byte_off_i,
    output logic [lsu_bus_pkg::DATA_W-1:0] wdata_o,
    output logic [lsu_bus_pkg::STRB_W-1:0] wstrb_o
);

    lsu_bus_pkg::lsu_word_u src;
    lsu_bus_pkg::lsu_word_u dst;

    assign src.word = rs2_data_i;
    assign wdata_o  = dst.word;

    // low byte or half copied to every lane, strobe picks the real one
    always_comb begin
        dst.word = src.word;
        wstrb_o  = '1;
        case (store_size_i)
            lsu_op_pkg::SB: begin
                for (int i = 0; i < lsu_bus_pkg::STRB_W; i++) begin
                    dst.bytes[i] = src.bytes[0];
                end
                wstrb_o = lsu_bus_pkg::STRB_W'(1) << byte_off_i;
            end
            lsu_op_pkg::SH: begin
                for (int i = 0; i < lsu_bus_pkg::STRB_W / 2; i++) begin
                    dst.halves[i] = src.halves[0];
                end
                wstrb_o = byte_off_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dst.word = src.word;
                wstrb_o  = '1;
            end
        endcase
    end

endmodule

//--- lsu_wdata_queue.sv
// depth must be a power of two; W beats leave in AW order and may run ahead of AW
module lsu_wdata_queue #(
    parameter int WDATA_QUEUE_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           store_fire_i,
    input  logic                           store_valid_i,
    input  logic [lsu_bus_pkg::DATA_W-1:0] wdata_i,
    input  logic [lsu_bus_pkg::STRB_W-1:0] wstrb_i,
    input  logic                           m_axi_wready_i,
    output logic                           m_axi_wvalid_o,
    output logic [lsu_bus_pkg::DATA_W-1:0] m_axi_wdata_o,
    output logic [lsu_bus_pkg::STRB_W-1:0] m_axi_wstrb_o,
    output logic                           full_o,
    output logic                           mem_busy_o
);

    localparam int PTR_W = $clog2(WDATA_QUEUE_DEPTH);

    logic [lsu_bus_pkg::DATA_W-1:0] data_q[WDATA_QUEUE_DEPTH];
    logic [lsu_bus_pkg::STRB_W-1:0] strb_q[WDATA_QUEUE_DEPTH];
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    logic [PTR_W:0]                 count;
    logic                           w_sent;
    logic                           empty;
    logic                           w_fire;
    logic                           push;
    logic                           pop;

    assign empty      = (count == '0);
    assign full_o     = (count == (PTR_W + 1)'(WDATA_QUEUE_DEPTH));
    assign mem_busy_o = ~empty;

    // empty queue passes the current store straight through
    assign m_axi_wvalid_o = empty ? (store_valid_i & ~w_sent) : 1'b1;
    assign m_axi_wdata_o  = empty ? wdata_i : data_q[rd_ptr];
    assign m_axi_wstrb_o  = empty ? wstrb_i : strb_q[rd_ptr];

    assign w_fire = m_axi_wvalid_o & m_axi_wready_i;
    assign pop    = w_fire & ~empty;
    // data still owed once the address is accepted
    assign push   = store_fire_i & ~w_sent & ~(w_fire & empty);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            w_sent <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // beat went out before its address, wait for AW
            if (store_fire_i) begin
                w_sent <= 1'b0;
            end else if (w_fire && empty) begin
                w_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[wr_ptr] <= wdata_i;
            strb_q[wr_ptr] <= wstrb_i;
        end
    end

endmodule

//--- lsu_load_queue.sv
// depth must be a power of two; RREADY is taken as always high and R returns in AR order
module lsu_load_queue #(
    parameter int LOAD_QUEUE_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                load_fire_i,
    input  lsu_op_pkg::load_kind_e              load_kind_i,
    input  logic [1:0]                          byte_off_i,
    input  logic [lsu_op_pkg::REG_ADDR_W-1:0]   rd_addr_i,
    input  logic [lsu_op_pkg::COMMIT_ID_W-1:0]  commit_id_i,
    input  logic                                m_axi_rvalid_i,
    output logic                                full_o,
    output logic                                rsp_valid_o,
    output lsu_op_pkg::load_kind_e              rsp_kind_o,
    output logic [1:0]                          rsp_off_o,
    output logic [lsu_op_pkg::REG_ADDR_W-1:0]   rsp_rd_o,
    output logic [lsu_op_pkg::COMMIT_ID_W-1:0]  rsp_commit_id_o
);

    localparam int PTR_W = $clog2(LOAD_QUEUE_DEPTH);

    lsu_op_pkg::load_kind_e               kind_q[LOAD_QUEUE_DEPTH];
    logic [1:0]                           off_q[LOAD_QUEUE_DEPTH];
    logic [lsu_op_pkg::REG_ADDR_W-1:0]    rd_q[LOAD_QUEUE_DEPTH];
    logic [lsu_op_pkg::COMMIT_ID_W-1:0]   cid_q[LOAD_QUEUE_DEPTH];
    logic [PTR_W-1:0]                     wr_ptr;
    logic [PTR_W-1:0]                     rd_ptr;
    logic [PTR_W:0]                       count;
    logic                                 empty;
    logic                                 bypass;
    logic                                 push;
    logic                                 pop;

    assign empty  = (count == '0);
    assign full_o = (count == (PTR_W + 1)'(LOAD_QUEUE_DEPTH));

    // beat in the same cycle as its AR, nothing older waiting
    assign bypass = m_axi_rvalid_i & empty & load_fire_i;
    assign pop    = m_axi_rvalid_i & ~empty;
    assign push   = load_fire_i & ~bypass;

    assign rsp_valid_o     = pop | bypass;
    assign rsp_kind_o      = empty ? load_kind_i : kind_q[rd_ptr];
    assign rsp_off_o       = empty ? byte_off_i : off_q[rd_ptr];
    assign rsp_rd_o        = empty ? rd_addr_i : rd_q[rd_ptr];
    assign rsp_commit_id_o = empty ? commit_id_i : cid_q[rd_ptr];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            kind_q[wr_ptr] <= load_kind_i;
            off_q[wr_ptr]  <= byte_off_i;
            rd_q[wr_ptr]   <= rd_addr_i;
            cid_q[wr_ptr]  <= commit_id_i;
        end
    end

endmodule

//--- lsu_load_extract.sv
// write-back lags the R beat by one cycle; halves use offset bit 1, words ignore the offset
module lsu_load_extract (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                rsp_valid_i,
    input  lsu_op_pkg::load_kind_e              rsp_kind_i,
    input  logic [1:0]                          rsp_off_i,
    input  logic [lsu_op_pkg::REG_ADDR_W-1:0]   rsp_rd_i,
    input  logic [lsu_op_pkg::COMMIT_ID_W-1:0]  rsp_commit_id_i,
    input  logic [lsu_bus_pkg::DATA_W-1:0]      m_axi_rdata_i,
    output logic                                reg_we_o,
    output logic [lsu_bus_pkg::DATA_W-1:0]      reg_wdata_o,
    output logic [lsu_op_pkg::REG_ADDR_W-1:0]   reg_waddr_o,
    output logic [lsu_op_pkg::COMMIT_ID_W-1:0]  commit_id_o
);

    lsu_bus_pkg::lsu_word_u         rdata;
    logic [7:0]                     lane_b;
    logic [15:0]                    lane_h;
    logic [lsu_bus_pkg::DATA_W-1:0] load_data;

    assign rdata.word = m_axi_rdata_i;
    assign lane_b     = rdata.bytes[rsp_off_i];
    assign lane_h     = rdata.halves[rsp_off_i[1]];

    // sign or zero extend by kind
    always_comb begin
        case (rsp_kind_i)
            lsu_op_pkg::LB:  load_data = {{24{lane_b[7]}}, lane_b};
            lsu_op_pkg::LBU: load_data = {24'h0, lane_b};
            lsu_op_pkg::LH:  load_data = {{16{lane_h[15]}}, lane_h};
            lsu_op_pkg::LHU: load_data = {16'h0, lane_h};
            default:         load_data = rdata.word;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_we_o <= 1'b0;
        end else begin
            reg_we_o <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid_i) begin
            reg_wdata_o <= load_data;
            reg_waddr_o <= rsp_rd_i;
            commit_id_o <= rsp_commit_id_i;
        end
    end

endmodule

//--- lsu_top.sv
// AXI slave must accept single-beat 32-bit transfers and always take R and B beats
module lsu_top #(
    parameter int LOAD_QUEUE_DEPTH  = 4,
    parameter int WDATA_QUEUE_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    // core request
    input  logic                                req_mem_i,
    input  logic                                mem_load_i,
    input  logic                                mem_store_i,
    input  logic                                int_assert_i,
    input  logic [lsu_bus_pkg::ADDR_W-1:0]      op1_i,
    input  logic [lsu_bus_pkg::ADDR_W-1:0]      op2_i,
    input  logic [lsu_bus_pkg::DATA_W-1:0]      rs2_data_i,
    input  lsu_op_pkg::load_kind_e              load_kind_i,
    input  lsu_op_pkg::store_size_e             store_size_i,
    input  logic [lsu_op_pkg::REG_ADDR_W-1:0]   rd_addr_i,
    input  logic [lsu_op_pkg::COMMIT_ID_W-1:0]  commit_id_i,
    output logic                                mem_stall_o,
    output logic                                mem_busy_o,
    // write-back
    output logic                                reg_we_o,
    output logic [lsu_bus_pkg::DATA_W-1:0]      reg_wdata_o,
    output logic [lsu_op_pkg::REG_ADDR_W-1:0]   reg_waddr_o,
    output logic [lsu_op_pkg::COMMIT_ID_W-1:0]  commit_id_o,
    // AXI master
    output logic [lsu_bus_pkg::ADDR_W-1:0]      m_axi_awaddr_o,
    output logic                                m_axi_awvalid_o,
    input  logic                                m_axi_awready_i,
    output logic [lsu_bus_pkg::DATA_W-1:0]      m_axi_wdata_o,
    output logic [lsu_bus_pkg::STRB_W-1:0]      m_axi_wstrb_o,
    output logic                                m_axi_wvalid_o,
    input  logic                                m_axi_wready_i,
    output logic [lsu_bus_pkg::ADDR_W-1:0]      m_axi_araddr_o,
    output logic                                m_axi_arvalid_o,
    input  logic                                m_axi_arready_i,
    input  logic [lsu_bus_pkg::DATA_W-1:0]      m_axi_rdata_i,
    input  logic                                m_axi_rvalid_i
);

    logic [lsu_bus_pkg::ADDR_W-1:0]     addr;
    logic [1:0]                         byte_off;
    logic                               load_fire;
    logic                               store_fire;
    logic                               lq_full;
    logic                               wq_full;
    logic [lsu_bus_pkg::DATA_W-1:0]     st_wdata;
    logic [lsu_bus_pkg::STRB_W-1:0]     st_wstrb;
    logic                               rsp_valid;
    lsu_op_pkg::load_kind_e             rsp_kind;
    logic [1:0]                         rsp_off;
    logic [lsu_op_pkg::REG_ADDR_W-1:0]  rsp_rd;
    logic [lsu_op_pkg::COMMIT_ID_W-1:0] rsp_commit_id;

    // one address serves both channels
    assign m_axi_awaddr_o = addr;
    assign m_axi_araddr_o = addr;

    lsu_issue lsu_issue_inst (
        .req_mem_i          (req_mem_i),
        .mem_load_i         (mem_load_i),
        .mem_store_i        (mem_store_i),
        .int_assert_i       (int_assert_i),
        .op1_i              (op1_i),
        .op2_i              (op2_i),
        .m_axi_arready_i    (m_axi_arready_i),
        .m_axi_awready_i    (m_axi_awready_i),
        .load_queue_full_i  (lq_full),
        .wdata_queue_full_i (wq_full),
        .addr_o             (addr),
        .byte_off_o         (byte_off),
        .load_fire_o        (load_fire),
        .store_fire_o       (store_fire),
        .m_axi_arvalid_o    (m_axi_arvalid_o),
        .m_axi_awvalid_o    (m_axi_awvalid_o),
        .mem_stall_o        (mem_stall_o)
    );

    lsu_store_align lsu_store_align_inst (
        .rs2_data_i   (rs2_data_i),
        .store_size_i (store_size_i),
        .byte_off_i   (byte_off),
        .wdata_o      (st_wdata),
        .wstrb_o      (st_wstrb)
    );

    lsu_wdata_queue #(
        .WDATA_QUEUE_DEPTH (WDATA_QUEUE_DEPTH)
    ) lsu_wdata_queue_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .store_fire_i   (store_fire),
        .store_valid_i  (m_axi_awvalid_o),
        .wdata_i        (st_wdata),
        .wstrb_i        (st_wstrb),
        .m_axi_wready_i (m_axi_wready_i),
        .m_axi_wvalid_o (m_axi_wvalid_o),
        .m_axi_wdata_o  (m_axi_wdata_o),
        .m_axi_wstrb_o  (m_axi_wstrb_o),
        .full_o         (wq_full),
        .mem_busy_o     (mem_busy_o)
    );

    lsu_load_queue #(
        .LOAD_QUEUE_DEPTH (LOAD_QUEUE_DEPTH)
    ) lsu_load_queue_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .load_fire_i     (load_fire),
        .load_kind_i     (load_kind_i),
        .byte_off_i      (byte_off),
        .rd_addr_i       (rd_addr_i),
        .commit_id_i     (commit_id_i),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .full_o          (lq_full),
        .rsp_valid_o     (rsp_valid),
        .rsp_kind_o      (rsp_kind),
        .rsp_off_o       (rsp_off),
        .rsp_rd_o        (rsp_rd),
        .rsp_commit_id_o (rsp_commit_id)
    );

    lsu_load_extract lsu_load_extract_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rsp_valid_i     (rsp_valid),
        .rsp_kind_i      (rsp_kind),
        .rsp_off_i       (rsp_off),
        .rsp_rd_i        (rsp_rd),
        .rsp_commit_id_i (rsp_commit_id),
        .m_axi_rdata_i   (m_axi_rdata_i),
        .reg_we_o        (reg_we_o),
        .reg_wdata_o     (reg_wdata_o),
        .reg_waddr_o     (reg_waddr_o),
        .commit_id_o     (commit_id_o)
    );

endmodule

//--- tb_lsu_mem_model.sv
// 256-byte memory, address bits above 7 ignored; R latency is taken from lat_i when AR transfers
module tb_lsu_mem_model (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] araddr_i,
    input  logic        ar_fire_i,
    input  logic [1:0]  lat_i,
    input  logic        r_hold_i,
    input  logic [31:0] awaddr_i,
    input  logic        aw_fire_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        w_fire_i,
    output logic [31:0] rdata_o,
    output logic        rvalid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem[256];
    logic [7:0]  rq_addr[16];
    logic [31:0] rq_due[16];
    logic [7:0]  aw_q[16];
    logic [31:0] wd_q[16];
    logic [3:0]  ws_q[16];
    logic [3:0]  rq_wr, rq_rd, aw_wr, aw_rd, w_wr, w_rd;
    logic [31:0] cyc;
    logic        head_rdy;
    logic        bypass;
    logic [7:0]  r_addr;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h5a;
        end
    end

    // oldest read first, a fresh AR may answer at once when nothing waits
    assign head_rdy = (rq_wr != rq_rd) && (cyc >= rq_due[rq_rd]) && !r_hold_i;
    assign bypass   = (rq_wr == rq_rd) && ar_fire_i && (lat_i == 2'd0) && !r_hold_i;
    assign rvalid_o = head_rdy | bypass;
    assign r_addr   = head_rdy ? rq_addr[rq_rd] : araddr_i[7:0];
    assign rdata_o  = {mem[{r_addr[7:2], 2'd3}], mem[{r_addr[7:2], 2'd2}],
                       mem[{r_addr[7:2], 2'd1}], mem[{r_addr[7:2], 2'd0}]};

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            {rq_wr, rq_rd, aw_wr, aw_rd, w_wr, w_rd} <= '0;
            cyc <= '0;
        end else begin
            cyc <= cyc + 32'd1;
            if (head_rdy) begin
                rq_rd <= rq_rd + 4'd1;
            end
            if (ar_fire_i && !bypass) begin
                rq_addr[rq_wr] <= araddr_i[7:0];
                rq_due[rq_wr]  <= cyc + ((lat_i == 2'd0) ? 32'd1 : 32'(lat_i));
                rq_wr          <= rq_wr + 4'd1;
            end
            if (aw_fire_i) begin
                aw_q[aw_wr] <= awaddr_i[7:0];
                aw_wr       <= aw_wr + 4'd1;
            end
            if (w_fire_i) begin
                wd_q[w_wr] <= wdata_i;
                ws_q[w_wr] <= wstrb_i;
                w_wr       <= w_wr + 4'd1;
            end
            // pair the oldest address with the oldest beat
            if (aw_wr != aw_rd && w_wr != w_rd) begin
                for (int b = 0; b < 4; b++) begin
                    if (ws_q[w_rd][b]) begin
                        mem[{aw_q[aw_rd][7:2], 2'(b)}] <= wd_q[w_rd][8*b +: 8];
                    end
                end
                aw_rd <= aw_rd + 4'd1;
                w_rd  <= w_rd + 4'd1;
            end
        end
    end

endmodule

//--- tb_lsu_top.sv
// addresses stay below 256 for the memory model; random loads read only the lower half
module tb_lsu_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RAND = 80;
    localparam int N_OPS  = N_RAND + 60;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_mem, mem_load, mem_store, int_assert;
    logic [31:0] op1, op2, rs2_data;
    lsu_op_pkg::load_kind_e  load_kind;
    lsu_op_pkg::store_size_e store_size;
    logic [4:0]  rd_addr, wb_waddr;
    logic [3:0]  commit_id, wb_cid;
    logic        mem_stall, mem_busy, wb_we;
    logic [31:0] wb_wdata, awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic        awvalid, awready, wvalid, wready, arvalid, arready, rvalid;
    logic [1:0]  lat;
    logic        r_hold, rand_ready;
    logic [31:0] lfsr = 32'h14ac;
    logic [7:0]  cur_addr;
    logic [7:0]  ref_mem[256];
    logic [40:0] exp_load[$];
    logic [35:0] exp_w[$];
    logic [35:0] got_w[$];
    int          val_errors = 0;
    int          seq_errors = 0;
    int          n_loads = 0;
    int          n_wb = 0;

    always #20 clk = ~clk;

    lsu_top lsu_top_inst (
        .clk(clk), .rst_n_i(rst_n), .req_mem_i(req_mem), .mem_load_i(mem_load),
        .mem_store_i(mem_store), .int_assert_i(int_assert), .op1_i(op1), .op2_i(op2),
        .rs2_data_i(rs2_data), .load_kind_i(load_kind), .store_size_i(store_size),
        .rd_addr_i(rd_addr), .commit_id_i(commit_id), .mem_stall_o(mem_stall),
        .mem_busy_o(mem_busy), .reg_we_o(wb_we), .reg_wdata_o(wb_wdata),
        .reg_waddr_o(wb_waddr), .commit_id_o(wb_cid), .m_axi_awaddr_o(awaddr),
        .m_axi_awvalid_o(awvalid), .m_axi_awready_i(awready), .m_axi_wdata_o(wdata),
        .m_axi_wstrb_o(wstrb), .m_axi_wvalid_o(wvalid), .m_axi_wready_i(wready),
        .m_axi_araddr_o(araddr), .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready),
        .m_axi_rdata_i(rdata), .m_axi_rvalid_i(rvalid)
    );

    tb_lsu_mem_model mem_model_inst (
        .clk(clk), .rst_n_i(rst_n), .araddr_i(araddr), .ar_fire_i(arvalid & arready),
        .lat_i(lat), .r_hold_i(r_hold), .awaddr_i(awaddr), .aw_fire_i(awvalid & awready),
        .wdata_i(wdata), .wstrb_i(wstrb), .w_fire_i(wvalid & wready),
        .rdata_o(rdata), .rvalid_o(rvalid)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] load_expect(input logic [7:0] a, input logic [2:0] kind);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[a];
        h = {ref_mem[{a[7:1], 1'b1}], ref_mem[{a[7:1], 1'b0}]};
        case (kind)
            3'd0:    return {{24{b[7]}}, b};
            3'd1:    return {{16{h[15]}}, h};
            3'd4:    return {24'h0, b};
            3'd5:    return {16'h0, h};
            default: return {ref_mem[{a[7:2], 2'd3}], ref_mem[{a[7:2], 2'd2}],
                             ref_mem[{a[7:2], 2'd1}], ref_mem[{a[7:2], 2'd0}]};
        endcase
    endfunction

    // strobe and data word a store puts on the bus
    function automatic logic [35:0] store_lanes(input logic [31:0] d, input logic [1:0] size,
                                                input logic [1:0] off);
        case (size)
            2'd0:    return {4'b0001 << off, {4{d[7:0]}}};
            2'd1:    return {off[1] ? 4'b1100 : 4'b0011, {2{d[15:0]}}};
            default: return {4'hf, d};
        endcase
    endfunction

    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            arready = rand_bits(1) != 0;
            awready = rand_bits(1) != 0;
            wready  = rand_bits(1) != 0;
        end
        lat = 2'(rand_bits(2));
    end

    always @(posedge clk) begin
        logic [35:0] lanes;
        logic [35:0] g;
        logic [40:0] e;
        if (arvalid && arready) begin
            exp_load.push_back({commit_id, rd_addr, load_expect(cur_addr, load_kind)});
            n_loads++;
        end
        if (awvalid && awready) begin
            lanes = store_lanes(rs2_data, store_size, cur_addr[1:0]);
            exp_w.push_back(lanes);
            for (int b = 0; b < 4; b++) begin
                if (lanes[32 + b]) begin
                    ref_mem[{cur_addr[7:2], 2'(b)}] = lanes[8*b +: 8];
                end
            end
        end
        if (wvalid && wready) begin
            got_w.push_back({wstrb, wdata});
        end
        if (exp_w.size() != 0 && got_w.size() != 0) begin
            lanes = exp_w.pop_front();
            g     = got_w.pop_front();
            assert (g[31:0] == lanes[31:0]) else begin
                val_errors++;
                $display("FAIL m_axi_wdata_o got %h expected %h", g[31:0], lanes[31:0]);
            end
            assert (g[35:32] == lanes[35:32]) else begin
                val_errors++;
                $display("FAIL m_axi_wstrb_o got %h expected %h", g[35:32], lanes[35:32]);
            end
        end
        if (wb_we) begin
            n_wb++;
            if (exp_load.size() == 0) begin
                val_errors++;
                $display("write-back seen with no load outstanding");
            end else begin
                e = exp_load.pop_front();
                assert (wb_wdata == e[31:0]) else begin
                    val_errors++;
                    $display("FAIL reg_wdata_o got %h expected %h", wb_wdata, e[31:0]);
                end
                assert (wb_waddr == e[36:32]) else begin
                    val_errors++;
                    $display("FAIL reg_waddr_o got %h expected %h", wb_waddr, e[36:32]);
                end
                assert (wb_cid == e[40:37]) else begin
                    val_errors++;
                    $display("FAIL commit_id_o got %h expected %h", wb_cid, e[40:37]);
                end
            end
        end
        if (int_assert) begin
            assert (!arvalid && !awvalid && !mem_stall) else begin
                val_errors++;
                $display("request not masked while the interrupt is high");
            end
        end
        if (req_mem && !int_assert && ((mem_load && !(arvalid && arready))
                || (mem_store && !(awvalid && awready)))) begin
            assert (mem_stall) else begin
                val_errors++;
                $display("request not accepted but the core was not stalled");
            end
        end
    end

    // caller is 2 ns past an edge; returns 2 ns past the accepting edge
    task automatic issue_op(input logic is_load, input logic [2:0] code,
                            input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] base;
        base       = rand_bits(7);
        op1        = base;
        op2        = {24'h0, addr} - base;
        cur_addr   = addr;
        load_kind  = lsu_op_pkg::load_kind_e'(code);
        store_size = lsu_op_pkg::store_size_e'(code[1:0]);
        rs2_data   = data;
        rd_addr    = 5'(rand_bits(5));
        commit_id  = 4'(rand_bits(4));
        req_mem    = 1'b1;
        mem_load   = is_load;
        mem_store  = !is_load;
        do @(posedge clk); while (mem_stall);
        #2;
        req_mem   = 1'b0;
        mem_load  = 1'b0;
        mem_store = 1'b0;
    endtask

    task automatic drain();
        while (exp_load.size() != 0 || mem_busy) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    function automatic logic [2:0] pick_kind(input logic [31:0] r);
        case (r % 5)
            0:       return 3'd0;
            1:       return 3'd1;
            2:       return 3'd2;
            3:       return 3'd4;
            default: return 3'd5;
        endcase
    endfunction

    initial begin
        #((N_OPS * 20 + 8) * 40);
        $display("run did not finish in time: %0d loads, %0d write-backs", n_loads, n_wb);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 8'(i) ^ 8'h5a;
        end
        {rst_n, req_mem, mem_load, mem_store, int_assert, r_hold, rand_ready} = '0;
        {op1, op2, rs2_data, rd_addr, commit_id, cur_addr} = '0;
        load_kind  = lsu_op_pkg::LW;
        store_size = lsu_op_pkg::SW;
        {arready, awready, wready} = 3'b111;
        lat = 2'd0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        assert (!wb_we && !mem_busy && !arvalid && !awvalid && !wvalid) else begin
            seq_errors++;
            $display("outputs not idle after reset");
        end
        // mixed traffic with stores only to the upper half
        rand_ready = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            if (rand_bits(1) != 0) begin
                issue_op(1'b1, pick_kind(rand_bits(8)), {1'b0, 7'(rand_bits(7))}, '0);
            end else begin
                issue_op(1'b0, 3'(rand_bits(8) % 3), {1'b1, 7'(rand_bits(7))}, rand_bits(32));
            end
        end
        rand_ready = 1'b0;
        {arready, awready, wready} = 3'b111;
        drain();
        // interrupt masks both kinds of request
        int_assert  = 1'b1;
        req_mem     = 1'b1;
        mem_load    = 1'b1;
        repeat (3) @(posedge clk);
        #2 mem_load = 1'b0;
        mem_store   = 1'b1;
        repeat (3) @(posedge clk);
        #2 {int_assert, req_mem, mem_store} = '0;
        assert (!mem_busy && exp_load.size() == 0) else begin
            seq_errors++;
            $display("queues changed while the interrupt was high");
        end
        // address channels back-pressured
        arready = 1'b0;
        awready = 1'b0;
        fork
            begin
                issue_op(1'b1, 3'd2, 8'h10, '0);
                issue_op(1'b0, 3'd2, 8'hc0, 32'h1234_abcd);
            end
            begin
                repeat (3) @(posedge clk);
                #2 arready = 1'b1;
                repeat (3) @(posedge clk);
                #2 awready = 1'b1;
            end
        join
        // load queue fills while R is held
        r_hold = 1'b1;
        fork
            for (int i = 0; i < 6; i++) begin
                issue_op(1'b1, pick_kind(rand_bits(8)), 8'(i * 5), '0);
            end
            begin
                repeat (10) @(posedge clk);
                #2 r_hold = 1'b0;
            end
        join
        drain();
        // data collects in the queue while W is held back
        wready = 1'b0;
        issue_op(1'b0, 3'd0, 8'hd1, 32'h0000_0077);
        assert (mem_busy) else begin
            seq_errors++;
            $display("mem_busy_o stayed low with a store beat queued");
        end
        fork
            for (int i = 0; i < 5; i++) begin
                issue_op(1'b0, 3'(i % 3), 8'he0 + 8'(i * 6), rand_bits(32));
            end
            begin
                repeat (10) @(posedge clk);
                #2 wready = 1'b1;
            end
        join
        drain();
        assert (!mem_busy) else begin
            seq_errors++;
            $display("mem_busy_o still high after all beats were sent");
        end
        // read back the whole upper half
        for (int i = 0; i < 32; i++) begin
            issue_op(1'b1, 3'd2, 8'h80 + 8'(i * 4), '0);
        end
        drain();
        assert (n_loads == n_wb && exp_w.size() == 0 && got_w.size() == 0) else begin
            seq_errors++;
            $display("loads and write-backs or W beats do not match up");
        end
        $display("errors: %0d value, %0d sequence; loads %0d, write-backs %0d",
                 val_errors, seq_errors, n_loads, n_wb);
        if (val_errors == 0 && seq_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
lsu_bus_pkg.sv
lsu_op_pkg.sv
lsu_issue.sv
lsu_store_align.sv
lsu_wdata_queue.sv
lsu_load_queue.sv
lsu_load_extract.sv
lsu_top.sv
tb_lsu_mem_model.sv
tb_lsu_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line in the log
verilator --binary --timing --top-module tb_lsu_top -f filelist.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -q "^Simulation finished: PASS$" sim.log \
    && echo "result: passed" \
    || { echo "result: failed, see sim.log"; exit 1; }
